//--- source/mm_settings.svh
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// Width of A and B elements and of instruction words
`define MM_DATA_W 16

// Accumulator and result width
`define MM_ACC_W 32

`define MM_ADDR_W 16

// Tile edge, also the inner dimension of every product
`define MM_TILE 4

`endif

//--- source/mm_pkg.sv
`default_nettype none

`include "mm_settings.svh"

package mm_pkg;

    typedef logic signed [`MM_DATA_W-1:0] data_t;
    typedef logic signed [`MM_ACC_W-1:0] acc_t;
    typedef logic [`MM_ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_FETCH,
        SQ_WAIT_INST,
        SQ_ISSUE,
        SQ_WAIT_FEED,
        SQ_FLUSH,
        SQ_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        FD_IDLE,
        FD_LOAD,
        FD_FEED
    } feed_state_e;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        acc_t  data;
    } mem_wr_t;

    // One tile order, stride is the N of the current product
    typedef struct packed {
        addr_t a_base;
        addr_t b_base;
        addr_t c_base;
        addr_t stride;
    } tile_req_t;

    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        data_t value;
    } step_t;

endpackage

`default_nettype wire

//--- source/mac_cell.sv
`default_nettype none

module mac_cell (
    input  logic          clk,
    input  logic          rst,
    input  mm_pkg::step_t a_in,
    input  mm_pkg::step_t b_in,
    output mm_pkg::step_t a_out,
    output mm_pkg::step_t b_out,
    output mm_pkg::acc_t  acc
);

    mm_pkg::acc_t prod;

    assign prod = mm_pkg::acc_t'(a_in.value) * mm_pkg::acc_t'(b_in.value);

    // Both operands move on one cell per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            a_out.valid <= 1'b0;
            b_out.valid <= 1'b0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    // The first step of a tile restarts the sum, so no separate clear is needed
    always_ff @(posedge clk) begin
        if (a_in.valid && b_in.valid) begin
            if (a_in.first) begin
                acc <= prod;
            end else begin
                acc <= acc + prod;
            end
        end
    end

    // Row and column skews must line up at every cell of the grid
    a_steps_aligned: assert property (
        @(posedge clk) disable iff (rst) a_in.valid == b_in.valid
    );

endmodule

`default_nettype wire

//--- source/tile_feeder.sv
`default_nettype none

`include "mm_settings.svh"

module tile_feeder (
    input  logic              clk,
    input  logic              rst,
    input  logic              tile_start,
    input  mm_pkg::tile_req_t tile_req,
    output logic              feed_busy,
    output mm_pkg::mem_rd_t   a_rd,
    output mm_pkg::mem_rd_t   b_rd,
    input  mm_pkg::data_t     a_rdata,
    input  mm_pkg::data_t     b_rdata,
    output mm_pkg::step_t     row_in [`MM_TILE],
    output mm_pkg::step_t     col_in [`MM_TILE],
    output mm_pkg::tile_req_t tile_info
);

    localparam int LW = $clog2(`MM_TILE);
    localparam int ELEMS = `MM_TILE * `MM_TILE;
    localparam int CW = 2 * LW + 1;
    // FEED lasts until the last step has crossed the longest skew lane
    localparam int FEED_END = 2 * `MM_TILE - 3;

    mm_pkg::feed_state_e state;
    logic [CW-1:0]       cnt;
    logic                issue;
    logic                cap_vld;
    logic [2*LW-1:0]     cap_idx;
    logic [LW-1:0]       ld_row;
    logic [LW-1:0]       ld_col;
    logic [LW-1:0]       k;
    logic                step_vld;
    mm_pkg::tile_req_t   req_q;
    mm_pkg::data_t       a_blk [`MM_TILE][`MM_TILE];
    mm_pkg::data_t       b_blk [`MM_TILE][`MM_TILE];
    mm_pkg::step_t       row_front [`MM_TILE];
    mm_pkg::step_t       col_front [`MM_TILE];

    assign feed_busy = (state != mm_pkg::FD_IDLE);
    assign issue = (state == mm_pkg::FD_LOAD) && (cnt < CW'(ELEMS));
    assign ld_row = cnt[2*LW-1:LW];
    assign ld_col = cnt[LW-1:0];

    // An A block row is MM_TILE wide, so the load index is already the offset
    always_comb begin
        a_rd.en   = issue;
        a_rd.addr = req_q.a_base + mm_pkg::addr_t'(cnt[2*LW-1:0]);
        b_rd.en   = issue;
        b_rd.addr = req_q.b_base + req_q.stride * mm_pkg::addr_t'(ld_row)
                  + mm_pkg::addr_t'(ld_col);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mm_pkg::FD_IDLE;
            cnt     <= '0;
            cap_vld <= 1'b0;
        end else begin
            cap_vld <= issue;
            case (state)
                mm_pkg::FD_IDLE: begin
                    if (tile_start) begin
                        state <= mm_pkg::FD_LOAD;
                        cnt   <= '0;
                    end
                end
                mm_pkg::FD_LOAD: begin
                    if (cnt == CW'(ELEMS)) begin
                        state <= mm_pkg::FD_FEED;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                mm_pkg::FD_FEED: begin
                    if (cnt == CW'(FEED_END)) begin
                        state <= mm_pkg::FD_IDLE;
                    end
                    cnt <= cnt + 1'b1;
                end
                default: begin
                    state <= mm_pkg::FD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cap_idx <= cnt[2*LW-1:0];
        if (state == mm_pkg::FD_IDLE && tile_start) begin
            req_q <= tile_req;
        end
        // The drain reads c_base and stride well after the next load has begun
        if (state == mm_pkg::FD_LOAD && cnt == CW'(ELEMS)) begin
            tile_info <= req_q;
        end
        if (cap_vld) begin
            a_blk[cap_idx[2*LW-1:LW]][cap_idx[LW-1:0]] <= a_rdata;
            b_blk[cap_idx[2*LW-1:LW]][cap_idx[LW-1:0]] <= b_rdata;
        end
    end

    assign step_vld = (state == mm_pkg::FD_FEED) && (cnt < CW'(`MM_TILE));
    assign k = cnt[LW-1:0];

    // Step k carries column k of A on the rows and row k of B on the columns
    always_comb begin
        for (int i = 0; i < `MM_TILE; i++) begin
            row_front[i].valid = step_vld;
            row_front[i].first = (k == '0);
            row_front[i].last  = (k == LW'(`MM_TILE - 1));
            row_front[i].value = a_blk[i][k];
            col_front[i]       = row_front[i];
            col_front[i].value = b_blk[k][i];
        end
    end

    for (genvar i = 0; i < `MM_TILE; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign row_in[i] = row_front[i];
            assign col_in[i] = col_front[i];
        end else begin : g_skew
            mm_pkg::step_t row_sr [i];
            mm_pkg::step_t col_sr [i];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int s = 0; s < i; s++) begin
                        row_sr[s].valid <= 1'b0;
                        col_sr[s].valid <= 1'b0;
                    end
                end else begin
                    row_sr[0] <= row_front[i];
                    col_sr[0] <= col_front[i];
                    for (int s = 1; s < i; s++) begin
                        row_sr[s] <= row_sr[s-1];
                        col_sr[s] <= col_sr[s-1];
                    end
                end
            end

            assign row_in[i] = row_sr[i-1];
            assign col_in[i] = col_sr[i-1];
        end
    end

    // A tile order that arrives while the blocks load would be lost
    a_load_only: assert property (
        @(posedge clk) disable iff (rst) a_rd.en |-> !tile_start
    );

endmodule

`default_nettype wire

//--- source/result_drain.sv
`default_nettype none

`include "mm_settings.svh"

module result_drain (
    input  logic              clk,
    input  logic              rst,
    input  mm_pkg::acc_t      acc_grid [`MM_TILE][`MM_TILE],
    input  mm_pkg::step_t     last_step,
    input  mm_pkg::tile_req_t tile_info,
    output mm_pkg::mem_wr_t   res_wr,
    output logic              drain_busy
);

    localparam int LW = $clog2(`MM_TILE);
    localparam int IW = 2 * LW;

    mm_pkg::acc_t  sums_q [`MM_TILE][`MM_TILE];
    mm_pkg::addr_t c_base_q;
    mm_pkg::addr_t stride_q;
    logic [IW-1:0] idx;
    logic [LW-1:0] wr_row;
    logic [LW-1:0] wr_col;
    logic          tile_end;

    // Last leaving the bottom right cell means every sum in the grid is final
    assign tile_end = last_step.valid && last_step.last;
    assign wr_row = idx[IW-1:LW];
    assign wr_col = idx[LW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            drain_busy <= 1'b0;
            idx        <= '0;
        end else if (tile_end) begin
            drain_busy <= 1'b1;
            idx        <= '0;
        end else if (drain_busy) begin
            idx <= idx + 1'b1;
            if (idx == '1) begin
                drain_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_end) begin
            sums_q   <= acc_grid;
            c_base_q <= tile_info.c_base;
            stride_q <= tile_info.stride;
        end
    end

    always_comb begin
        res_wr.en   = drain_busy;
        res_wr.addr = c_base_q + stride_q * mm_pkg::addr_t'(wr_row)
                    + mm_pkg::addr_t'(wr_col);
        res_wr.data = sums_q[wr_row][wr_col];
    end

    // A new tile may only finish once the previous one has been written out
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) tile_end |-> !drain_busy
    );

endmodule

`default_nettype wire

//--- source/mm_sequencer.sv
`default_nettype none

`include "mm_settings.svh"

module mm_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              ap_start,
    output logic              ap_done,
    output mm_pkg::mem_rd_t   inst_rd,
    input  mm_pkg::data_t     inst_rdata,
    input  logic              feed_busy,
    input  logic              drain_busy,
    output logic              tile_start,
    output mm_pkg::tile_req_t tile_req
);

    localparam int LW = $clog2(`MM_TILE);
    // The grid still holds a tile for a few cycles after the feeder goes idle
    localparam int QUIET = 2 * `MM_TILE;
    localparam int QW = $clog2(QUIET);

    mm_pkg::seq_state_e state;
    logic               start_q;
    logic               start_edge;
    logic [QW-1:0]      quiet_cnt;
    logic               quiet;
    mm_pkg::addr_t      inst_ptr;
    mm_pkg::addr_t      a_base;
    mm_pkg::addr_t      b_base;
    mm_pkg::addr_t      c_base;
    mm_pkg::addr_t      n_q;
    mm_pkg::addr_t      blk_row;
    mm_pkg::addr_t      blk_col;
    mm_pkg::addr_t      blk_last;
    logic               col_wrap;
    logic               row_wrap;

    assign start_edge = ap_start && !start_q;
    assign quiet = !feed_busy && !drain_busy;

    assign blk_last = (n_q >> LW) - mm_pkg::addr_t'(1);
    assign col_wrap = (blk_col == blk_last);
    assign row_wrap = (blk_row == blk_last);

    assign ap_done = (state == mm_pkg::SQ_IDLE) || (state == mm_pkg::SQ_DONE);
    assign inst_rd.en = (state == mm_pkg::SQ_FETCH);
    assign inst_rd.addr = inst_ptr;
    assign tile_start = (state == mm_pkg::SQ_ISSUE);

    // A blocks are contiguous, B blocks sit side by side in each row of B
    always_comb begin
        tile_req.a_base = a_base + (blk_row << (2 * LW));
        tile_req.b_base = b_base + (blk_col << LW);
        tile_req.c_base = c_base + ((n_q * blk_row) << LW) + (blk_col << LW);
        tile_req.stride = n_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= mm_pkg::SQ_IDLE;
            start_q   <= 1'b0;
            quiet_cnt <= '0;
        end else begin
            start_q <= ap_start;
            case (state)
                mm_pkg::SQ_IDLE, mm_pkg::SQ_DONE: begin
                    if (start_edge) begin
                        state <= mm_pkg::SQ_FETCH;
                    end
                end
                mm_pkg::SQ_FETCH: begin
                    state <= mm_pkg::SQ_WAIT_INST;
                end
                mm_pkg::SQ_WAIT_INST: begin
                    if (inst_rdata == '0) begin
                        state <= mm_pkg::SQ_FLUSH;
                    end else begin
                        state <= mm_pkg::SQ_WAIT_FEED;
                    end
                end
                mm_pkg::SQ_WAIT_FEED: begin
                    if (!feed_busy) begin
                        state <= mm_pkg::SQ_ISSUE;
                    end
                end
                mm_pkg::SQ_ISSUE: begin
                    if (col_wrap && row_wrap) begin
                        state <= mm_pkg::SQ_FETCH;
                    end else begin
                        state <= mm_pkg::SQ_WAIT_FEED;
                    end
                end
                mm_pkg::SQ_FLUSH: begin
                    if (quiet && quiet_cnt == QW'(QUIET - 1)) begin
                        state <= mm_pkg::SQ_DONE;
                    end
                end
                default: begin
                    state <= mm_pkg::SQ_IDLE;
                end
            endcase
            if (state == mm_pkg::SQ_FLUSH && quiet) begin
                quiet_cnt <= quiet_cnt + 1'b1;
            end else begin
                quiet_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            mm_pkg::SQ_IDLE, mm_pkg::SQ_DONE: begin
                if (start_edge) begin
                    inst_ptr <= '0;
                    a_base   <= '0;
                    b_base   <= '0;
                    c_base   <= '0;
                end
            end
            mm_pkg::SQ_WAIT_INST: begin
                n_q     <= mm_pkg::addr_t'(inst_rdata);
                blk_row <= '0;
                blk_col <= '0;
            end
            mm_pkg::SQ_ISSUE: begin
                if (!col_wrap) begin
                    blk_col <= blk_col + mm_pkg::addr_t'(1);
                end else begin
                    blk_col <= '0;
                    if (!row_wrap) begin
                        blk_row <= blk_row + mm_pkg::addr_t'(1);
                    end else begin
                        // Product finished, move on to the next operands
                        blk_row  <= '0;
                        inst_ptr <= inst_ptr + mm_pkg::addr_t'(1);
                        a_base   <= a_base + (n_q << LW);
                        b_base   <= b_base + (n_q << LW);
                        c_base   <= c_base + n_q * n_q;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    a_no_strobe_busy: assert property (
        @(posedge clk) disable iff (rst) tile_start |-> !feed_busy
    );

endmodule

`default_nettype wire

//--- source/mm_top.sv
`default_nettype none

`include "mm_settings.svh"

module mm_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            ap_start,
    output logic            ap_done,
    output mm_pkg::mem_rd_t inst_rd,
    input  mm_pkg::data_t   inst_rdata,
    output mm_pkg::mem_rd_t a_rd,
    input  mm_pkg::data_t   a_rdata,
    output mm_pkg::mem_rd_t b_rd,
    input  mm_pkg::data_t   b_rdata,
    output mm_pkg::mem_wr_t res_wr
);

    logic              feed_busy;
    logic              drain_busy;
    logic              tile_start;
    mm_pkg::tile_req_t tile_req;
    mm_pkg::tile_req_t tile_info;
    mm_pkg::step_t     row_in [`MM_TILE];
    mm_pkg::step_t     col_in [`MM_TILE];
    // Row steps travel right and column steps down, index 0 is the feeder edge
    mm_pkg::step_t     a_link [`MM_TILE][`MM_TILE+1];
    mm_pkg::step_t     b_link [`MM_TILE+1][`MM_TILE];
    mm_pkg::acc_t      acc_grid [`MM_TILE][`MM_TILE];

    mm_sequencer i_sequencer (
        .clk        (clk),
        .rst        (rst),
        .ap_start   (ap_start),
        .ap_done    (ap_done),
        .inst_rd    (inst_rd),
        .inst_rdata (inst_rdata),
        .feed_busy  (feed_busy),
        .drain_busy (drain_busy),
        .tile_start (tile_start),
        .tile_req   (tile_req)
    );

    tile_feeder i_feeder (
        .clk        (clk),
        .rst        (rst),
        .tile_start (tile_start),
        .tile_req   (tile_req),
        .feed_busy  (feed_busy),
        .a_rd       (a_rd),
        .b_rd       (b_rd),
        .a_rdata    (a_rdata),
        .b_rdata    (b_rdata),
        .row_in     (row_in),
        .col_in     (col_in),
        .tile_info  (tile_info)
    );

    for (genvar e = 0; e < `MM_TILE; e++) begin : g_edge
        assign a_link[e][0] = row_in[e];
        assign b_link[0][e] = col_in[e];
    end

    for (genvar i = 0; i < `MM_TILE; i++) begin : g_row
        for (genvar j = 0; j < `MM_TILE; j++) begin : g_col
            mac_cell i_cell (
                .clk   (clk),
                .rst   (rst),
                .a_in  (a_link[i][j]),
                .b_in  (b_link[i][j]),
                .a_out (a_link[i][j+1]),
                .b_out (b_link[i+1][j]),
                .acc   (acc_grid[i][j])
            );
        end
    end

    result_drain i_drain (
        .clk        (clk),
        .rst        (rst),
        .acc_grid   (acc_grid),
        .last_step  (b_link[`MM_TILE][`MM_TILE-1]),
        .tile_info  (tile_info),
        .res_wr     (res_wr),
        .drain_busy (drain_busy)
    );

endmodule

`default_nettype wire

//--- sim/tb_mm_model.svh
`ifndef TB_MM_MODEL_SVH
`define TB_MM_MODEL_SVH

localparam int MEM_DEPTH = 1 << `MM_ADDR_W;

// Instruction and operand images behind the DUT read ports
mm_pkg::data_t inst_mem [MEM_DEPTH];
mm_pkg::data_t a_mem [MEM_DEPTH];
mm_pkg::data_t b_mem [MEM_DEPTH];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Maps a random word onto -200..200
function automatic mm_pkg::data_t small_value(input logic [31:0] x);
    return mm_pkg::data_t'(int'(x % 401) - 200);
endfunction

task automatic fill_memories();
    logic [31:0] x;
    x = 32'h8f4f;
    for (int i = 0; i < MEM_DEPTH; i++) begin
        x = xorshift32(x);
        a_mem[i] = small_value(x);
        x = xorshift32(x);
        b_mem[i] = small_value(x);
        inst_mem[i] = '0;
    end
endtask

// One element of C = A x B, A is n by 4 and B is 4 by n, both row-major
function automatic mm_pkg::acc_t ref_elem(input mm_pkg::addr_t a_base,
                                          input mm_pkg::addr_t b_base,
                                          input int n, input int r, input int c);
    mm_pkg::acc_t  sum;
    mm_pkg::addr_t a_addr;
    mm_pkg::addr_t b_addr;
    sum = '0;
    for (int k = 0; k < `MM_TILE; k++) begin
        a_addr = a_base + mm_pkg::addr_t'(`MM_TILE * r + k);
        b_addr = b_base + mm_pkg::addr_t'(n * k + c);
        sum = sum + mm_pkg::acc_t'(a_mem[a_addr]) * mm_pkg::acc_t'(b_mem[b_addr]);
    end
    return sum;
endfunction

task automatic check_addr(input mm_pkg::addr_t expected, input mm_pkg::addr_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("error %s: write address expected 0x%0h actual 0x%0h",
                            test_name, expected, actual));
    end
endtask

task automatic check_data(input mm_pkg::acc_t expected, input mm_pkg::acc_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("error %s: write data expected %0d actual %0d",
                            test_name, expected, actual));
    end
endtask

task automatic check_done(input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("error %s: ap_done expected %b actual %b",
                            test_name, expected, actual));
    end
endtask

`endif

//--- sim/tb_mm_top.sv
`default_nettype none

`include "mm_settings.svh"

module tb_mm_top;

    timeunit 1ns;
    timeprecision 1ps;

    logic            clk;
    logic            rst;
    logic            ap_start;
    logic            ap_done;
    mm_pkg::mem_rd_t inst_rd;
    mm_pkg::data_t   inst_rdata;
    mm_pkg::mem_rd_t a_rd;
    mm_pkg::data_t   a_rdata;
    mm_pkg::mem_rd_t b_rd;
    mm_pkg::data_t   b_rdata;
    mm_pkg::mem_wr_t res_wr;

    string           test_name;
    int              write_count;
    mm_pkg::addr_t   exp_addr_q [$];
    mm_pkg::acc_t    exp_data_q [$];

    `include "tb_mm_model.svh"

    mm_top i_mm_top (
        .clk        (clk),
        .rst        (rst),
        .ap_start   (ap_start),
        .ap_done    (ap_done),
        .inst_rd    (inst_rd),
        .inst_rdata (inst_rdata),
        .a_rd       (a_rd),
        .a_rdata    (a_rdata),
        .b_rd       (b_rd),
        .b_rdata    (b_rdata),
        .res_wr     (res_wr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // All three memories answer one cycle after the request
    always @(posedge clk) begin
        if (inst_rd.en === 1'b1) begin
            inst_rdata <= inst_mem[inst_rd.addr];
        end
        if (a_rd.en === 1'b1) begin
            a_rdata <= a_mem[a_rd.addr];
        end
        if (b_rd.en === 1'b1) begin
            b_rdata <= b_mem[b_rd.addr];
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic set_list(input int w0, input int w1, input int w2);
        inst_mem[0] = mm_pkg::data_t'(w0);
        inst_mem[1] = mm_pkg::data_t'(w1);
        inst_mem[2] = mm_pkg::data_t'(w2);
        inst_mem[3] = '0;
    endtask

    // Walks the instruction list and queues every write in tile order
    task automatic expect_list();
        mm_pkg::addr_t a_base;
        mm_pkg::addr_t b_base;
        mm_pkg::addr_t c_base;
        int            ip;
        int            n;
        int            row;
        int            col;
        exp_addr_q.delete();
        exp_data_q.delete();
        a_base = '0;
        b_base = '0;
        c_base = '0;
        ip = 0;
        n = int'(inst_mem[0]);
        while (n != 0 && ip < 16) begin
            for (int tr = 0; tr < n / `MM_TILE; tr++) begin
                for (int tc = 0; tc < n / `MM_TILE; tc++) begin
                    for (int r = 0; r < `MM_TILE; r++) begin
                        for (int c = 0; c < `MM_TILE; c++) begin
                            row = `MM_TILE * tr + r;
                            col = `MM_TILE * tc + c;
                            exp_addr_q.push_back(c_base + mm_pkg::addr_t'(n * row + col));
                            exp_data_q.push_back(ref_elem(a_base, b_base, n, row, col));
                        end
                    end
                end
            end
            a_base = a_base + mm_pkg::addr_t'(`MM_TILE * n);
            b_base = b_base + mm_pkg::addr_t'(`MM_TILE * n);
            c_base = c_base + mm_pkg::addr_t'(n * n);
            ip++;
            n = int'(inst_mem[ip]);
        end
    endtask

    task automatic wait_for_done(input logic level, input int limit, input string what);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            if (ap_done === level) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            abort_run($sformatf("%s: timed out after %0d cycles waiting for %s",
                                test_name, limit, what));
        end
    endtask

    task automatic run_list(input string name, input bit hold, input int writes);
        test_name = name;
        write_count = 0;
        expect_list();
        @(posedge clk);
        ap_start <= 1'b1;
        if (!hold) begin
            @(posedge clk);
            ap_start <= 1'b0;
        end
        wait_for_done(1'b0, 20, "ap_done to fall after the start edge");
        wait_for_done(1'b1, 6000, "ap_done to return high");
        if (exp_addr_q.size() != 0) begin
            abort_run($sformatf("%s: run ended with %0d result writes still missing",
                                test_name, exp_addr_q.size()));
        end
        if (write_count != writes) begin
            abort_run($sformatf("error %s: write count expected %0d actual %0d",
                                test_name, writes, write_count));
        end
    endtask

    // Every result write must match the head of the expected queue
    initial begin
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && res_wr.en === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    abort_run($sformatf("%s: unexpected result write to address 0x%0h",
                                        test_name, res_wr.addr));
                end else begin
                    check_addr(exp_addr_q.pop_front(), res_wr.addr);
                    check_data(exp_data_q.pop_front(), res_wr.data);
                    write_count++;
                end
            end
        end
    end

    initial begin
        rst <= 1'b1;
        ap_start <= 1'b0;
        inst_rdata <= '0;
        a_rdata <= '0;
        b_rdata <= '0;
        test_name = "reset";
        write_count = 0;
        fill_memories();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_done(1'b1, ap_done);
        repeat (20) @(negedge clk);
        check_done(1'b1, ap_done);

        set_list(4, 0, 0);
        run_list("single_n4", 1'b0, 16);

        set_list(12, 0, 0);
        run_list("single_n12", 1'b0, 144);

        set_list(8, 4, 0);
        run_list("list_8_4", 1'b0, 80);

        // A held ap_start gives one run only
        run_list("relaunch", 1'b1, 80);
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
            check_done(1'b1, ap_done);
        end
        @(posedge clk);
        ap_start <= 1'b0;

        set_list(0, 0, 0);
        run_list("empty_list", 1'b0, 0);

        repeat (10) @(negedge clk);
        check_done(1'b1, ap_done);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+source
+incdir+sim
source/mm_pkg.sv
source/mac_cell.sv
source/tile_feeder.sv
source/result_drain.sv
source/mm_sequencer.sv
source/mm_top.sv
sim/tb_mm_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_mm_top -Mdir obj_dir -o tb_mm_top

./obj_dir/tb_mm_top | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation FAILED, see sim.log"
    exit 1
fi
